// File: id_pkg.sv
// Decode stage shared definitions: opcodes, ALU codes, register numbers, pipeline structs
package id_pkg;

    // Instruction opcodes, inst[15:12]
    typedef enum logic [3:0] {
        ADD  = 4'h0,
        SUB  = 4'h1,
        AND  = 4'h2,
        NOR  = 4'h3,
        SLL  = 4'h4,
        SRL  = 4'h5,
        SRA  = 4'h6,
        NOP7 = 4'h7,
        LW   = 4'h8,
        SW   = 4'h9,
        LHB  = 4'hA,
        LLB  = 4'hB,
        BR   = 4'hC,
        CALL = 4'hD,
        RET  = 4'hE,
        HLT  = 4'hF
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD  = 3'd0,
        ALU_SUB  = 3'd1,
        ALU_AND  = 3'd2,
        ALU_NOR  = 3'd3,
        ALU_SLL  = 3'd4,
        ALU_SRL  = 3'd5,
        ALU_SRA  = 3'd6,
        ALU_NONE = 3'd7  // Bubble, ALU idle
    } alu_op_e;

    localparam logic [3:0] SP_REG = 4'd15;  // Stack pointer
    localparam logic [3:0] DS_REG = 4'd14;  // Data segment base

    typedef struct packed {
        logic [15:0] instr;
        logic [15:0] pc;
    } if_id_t;

    typedef struct packed {
        logic    reg_write;
        logic    mem_write;
        logic    mem_read;
        logic    mem_to_reg;  // Write back from memory
        logic    alu_src;     // Immediate as operand B
        alu_op_e alu_op;
        logic    branch;
        logic    call;
        logic    ret;
        logic    load_half;
        logic    half_spec;   // 0 -> LHB, 1 -> LLB
    } ctrl_t;

    // Destination that is about to be written
    typedef struct packed {
        logic       wr;
        logic [3:0] rd;
    } dest_t;

    typedef struct packed {
        logic        en;
        logic [3:0]  rd;
        logic [15:0] data;
    } wb_t;

    typedef struct packed {
        ctrl_t       ctrl;
        logic [15:0] read_data_1;
        logic [15:0] read_data_2;
        logic [15:0] sign_ext;
        logic [3:0]  rd;           // Also load/save register
        logic [2:0]  branch_cond;
        logic [11:0] call_target;
        logic [15:0] pc;
    } id_ex_t;

    localparam ctrl_t  CTRL_BUBBLE  = '{alu_op: ALU_NONE, default: '0};
    localparam if_id_t IF_ID_RESET  = '{instr: {NOP7, 12'h000}, pc: 16'h0000};
    localparam id_ex_t ID_EX_BUBBLE = '{ctrl: CTRL_BUBBLE, default: '0};

endpackage

// File: reg_file.sv
// Register file: sixteen 16-bit registers, two reads with DS/SP select, one synchronous write
`timescale 1ns/10ps

module reg_file (
    input  logic        clk,
    input  logic        we,
    input  logic [3:0]  wr_reg,
    input  logic [15:0] wr_data,
    input  logic [3:0]  rd_reg_1,
    input  logic [3:0]  rd_reg_2,
    input  logic        data_reg,     // Port 1 reads data segment reg
    input  logic        stack_reg,    // Port 1 reads stack pointer
    output logic [15:0] read_data_1,
    output logic [15:0] read_data_2
);

    logic [15:0] regs [16];
    logic [3:0]  sel_1;  // Effective port 1 address

    // Write lands on the edge, same-cycle read sees old value
    always_ff @(posedge clk) begin
        if (we) begin
            regs[wr_reg] <= wr_data;
        end
    end

    // Port 1 source select
    always_comb begin
        if (data_reg) begin
            sel_1 = id_pkg::DS_REG;  // LW/SW base
        end else if (stack_reg) begin
            sel_1 = id_pkg::SP_REG;  // CALL/RET
        end else begin
            sel_1 = rd_reg_1;
        end
    end

    assign read_data_1 = regs[sel_1];
    assign read_data_2 = regs[rd_reg_2];  // No select on port 2

endmodule

// File: control_decoder.sv
// Control decoder: opcode to execute, memory and write-back controls plus decode-local selects
`timescale 1ns/10ps

module control_decoder (
    input  id_pkg::opcode_e opcode,
    output id_pkg::ctrl_t   ctrl,
    output logic            data_reg,    // Port 1 from DS reg
    output logic            stack_reg,   // Port 1 from SP
    output logic            rt_from_rd,  // rt taken from inst[11:8]
    output logic            sext_wide    // Extend imm8, else imm4
);

    always_comb begin
        // Defaults give the bubble control
        ctrl       = id_pkg::CTRL_BUBBLE;
        data_reg   = 1'b0;
        stack_reg  = 1'b0;
        rt_from_rd = 1'b0;
        sext_wide  = 1'b0;

        case (opcode)
            id_pkg::ADD: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = id_pkg::ALU_ADD;
            end
            id_pkg::SUB: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = id_pkg::ALU_SUB;
            end
            id_pkg::AND: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = id_pkg::ALU_AND;
            end
            id_pkg::NOR: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = id_pkg::ALU_NOR;
            end
            // Shifts take the 4-bit immediate as amount
            id_pkg::SLL, id_pkg::SRL, id_pkg::SRA: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = (opcode == id_pkg::SLL) ? id_pkg::ALU_SLL :
                                 (opcode == id_pkg::SRL) ? id_pkg::ALU_SRL : id_pkg::ALU_SRA;
            end
            id_pkg::LW: begin
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.reg_write  = 1'b1;
                ctrl.alu_src    = 1'b1;
                ctrl.alu_op     = id_pkg::ALU_ADD;  // DS + imm8
                data_reg        = 1'b1;
                sext_wide       = 1'b1;
            end
            id_pkg::SW: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = id_pkg::ALU_ADD;
                data_reg       = 1'b1;
                rt_from_rd     = 1'b1;  // Store data reg in [11:8]
                sext_wide      = 1'b1;
            end
            id_pkg::LHB, id_pkg::LLB: begin
                ctrl.load_half = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.half_spec = (opcode == id_pkg::LLB);
                rt_from_rd     = 1'b1;  // Keeps the other half
                sext_wide      = 1'b1;
            end
            id_pkg::BR:   ctrl.branch = 1'b1;
            id_pkg::CALL: begin
                ctrl.call = 1'b1;
                stack_reg = 1'b1;
            end
            id_pkg::RET: begin
                ctrl.ret  = 1'b1;
                stack_reg = 1'b1;
            end
            default: ctrl = id_pkg::CTRL_BUBBLE;  // NOP7, HLT
        endcase
    end

endmodule

// File: hazard_unit.sv
// Hazard unit: register conflict detection and the call/return PC-hazard flag
`timescale 1ns/10ps

module hazard_unit (
    input  logic          clk,
    input  logic          rst,
    input  logic [3:0]    rs,
    input  logic [3:0]    rt,
    input  logic          uses_rs,
    input  logic          uses_rt,
    input  id_pkg::dest_t id_ex_dst,
    input  id_pkg::dest_t ex_mem_dst,
    input  id_pkg::dest_t mem_wb_dst,
    input  logic          call,       // Raw decoder output
    input  logic          ret,
    input  logic          pc_update,  // New PC resolved downstream
    output logic          data_hazard,
    output logic          pc_hazard
);

    logic rs_hit;
    logic rt_hit;

    // Any pending writer of the register
    function automatic logic pending(input id_pkg::dest_t dst, input logic [3:0] src);
        return dst.wr && (dst.rd == src);
    endfunction

    always_comb begin
        rs_hit = pending(id_ex_dst, rs) | pending(ex_mem_dst, rs) | pending(mem_wb_dst, rs);
        rt_hit = pending(id_ex_dst, rt) | pending(ex_mem_dst, rt) | pending(mem_wb_dst, rt);
    end

    // MEM_WB also covers the old-value read during write-back
    assign data_hazard = (uses_rs & rs_hit) | (uses_rt & rt_hit);

    // Set by accepted CALL/RET, held until the PC update
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_hazard <= 1'b0;
        end else if (pc_hazard) begin
            if (pc_update) begin
                pc_hazard <= 1'b0;
            end
        end else if ((call | ret) && !data_hazard) begin
            pc_hazard <= 1'b1;  // Only when not stalled
        end
    end

endmodule

// File: pipe_reg.sv
// Pipeline register for any payload, with stall hold and bubble load
`timescale 1ns/10ps

module pipe_reg #(
    parameter type      payload_t = logic [31:0],
    parameter payload_t BUBBLE    = '0
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     hold,    // Keep current contents
    input  logic     bubble,  // Insert empty slot
    input  payload_t d,
    output payload_t q
);

    // Bubble wins over hold
    always_ff @(posedge clk) begin
        if (rst || bubble) begin
            q <= BUBBLE;
        end else if (!hold) begin
            q <= d;
        end
    end

endmodule

// File: decode_stage.sv
// Decode datapath: field split, operand read, sign extension, hazard bubble and SP reset write
`timescale 1ns/10ps

module decode_stage (
    input  logic           clk,
    input  logic           rst,
    input  id_pkg::if_id_t if_id,
    input  id_pkg::wb_t    wb,
    input  id_pkg::dest_t  id_ex_dst,
    input  id_pkg::dest_t  ex_mem_dst,
    input  id_pkg::dest_t  mem_wb_dst,
    input  logic           pc_update,
    output id_pkg::id_ex_t decoded,
    output logic           stall
);

    id_pkg::opcode_e opcode;
    id_pkg::ctrl_t   dec_ctrl;      // Before the bubble mux
    id_pkg::wb_t     wb_eff;        // Write port after reset mux
    logic [3:0]      rs;
    logic [3:0]      rt;
    logic            data_reg;
    logic            stack_reg;
    logic            rt_from_rd;
    logic            sext_wide;
    logic            uses_rs;
    logic            uses_rt;
    logic            data_hazard;
    logic            pc_hazard;

    assign opcode = id_pkg::opcode_e'(if_id.instr[15:12]);
    assign rs     = if_id.instr[7:4];
    assign rt     = rt_from_rd ? if_id.instr[11:8] : if_id.instr[3:0];

    // Source registers actually read, per opcode
    always_comb begin
        uses_rs = 1'b0;
        uses_rt = 1'b0;
        case (opcode)
            id_pkg::ADD, id_pkg::SUB, id_pkg::AND, id_pkg::NOR: begin
                uses_rs = 1'b1;
                uses_rt = 1'b1;
            end
            id_pkg::SLL, id_pkg::SRL, id_pkg::SRA: uses_rs = 1'b1;
            id_pkg::SW, id_pkg::LHB, id_pkg::LLB:  uses_rt = 1'b1;  // rt is [11:8] here
            default: ;  // Port 1 from DS/SP or no reads
        endcase
    end

    // SP forced to all ones while in reset
    always_comb begin
        if (rst) begin
            wb_eff = '{en: 1'b1, rd: id_pkg::SP_REG, data: 16'hFFFF};
        end else begin
            wb_eff = wb;
        end
    end

    reg_file u_reg_file (
        .clk         (clk),
        .we          (wb_eff.en),
        .wr_reg      (wb_eff.rd),
        .wr_data     (wb_eff.data),
        .rd_reg_1    (rs),
        .rd_reg_2    (rt),
        .data_reg    (data_reg),
        .stack_reg   (stack_reg),
        .read_data_1 (decoded.read_data_1),
        .read_data_2 (decoded.read_data_2)
    );

    control_decoder u_ctrl (
        .opcode     (opcode),
        .ctrl       (dec_ctrl),
        .data_reg   (data_reg),
        .stack_reg  (stack_reg),
        .rt_from_rd (rt_from_rd),
        .sext_wide  (sext_wide)
    );

    hazard_unit u_hazard (
        .clk         (clk),
        .rst         (rst),
        .rs          (rs),
        .rt          (rt),
        .uses_rs     (uses_rs),
        .uses_rt     (uses_rt),
        .id_ex_dst   (id_ex_dst),
        .ex_mem_dst  (ex_mem_dst),
        .mem_wb_dst  (mem_wb_dst),
        .call        (dec_ctrl.call),
        .ret         (dec_ctrl.ret),
        .pc_update   (pc_update),
        .data_hazard (data_hazard),
        .pc_hazard   (pc_hazard)
    );

    assign stall = data_hazard | pc_hazard;

    // Bubble only touches control, data fields pass through
    assign decoded.ctrl        = stall ? id_pkg::CTRL_BUBBLE : dec_ctrl;
    assign decoded.sign_ext    = sext_wide ? {{8{if_id.instr[7]}}, if_id.instr[7:0]}
                                           : {{12{if_id.instr[3]}}, if_id.instr[3:0]};
    assign decoded.rd          = if_id.instr[11:8];
    assign decoded.branch_cond = if_id.instr[10:8];
    assign decoded.call_target = if_id.instr[11:0];
    assign decoded.pc          = if_id.pc;

endmodule

// File: decode_top.sv
// Decode top: IF/ID register, decode stage and ID/EX register with stall handshake
`timescale 1ns/10ps

module decode_top (
    input  logic           clk,
    input  logic           rst,
    input  id_pkg::if_id_t fetch,
    input  id_pkg::wb_t    wb,
    input  id_pkg::dest_t  ex_mem_dst,
    input  id_pkg::dest_t  mem_wb_dst,
    input  logic           pc_update,
    output id_pkg::id_ex_t id_ex,
    output logic           stall       // Freezes fetch
);

    id_pkg::if_id_t if_id;
    id_pkg::id_ex_t decoded;
    id_pkg::dest_t  id_ex_dst;

    // Instruction now in execute, fed back for hazard checks
    assign id_ex_dst = '{wr: id_ex.ctrl.reg_write, rd: id_ex.rd};

    pipe_reg #(
        .payload_t (id_pkg::if_id_t),
        .BUBBLE    (id_pkg::IF_ID_RESET)  // NOP7 after reset
    ) if_id_reg (
        .clk    (clk),
        .rst    (rst),
        .hold   (stall),
        .bubble (1'b0),
        .d      (fetch),
        .q      (if_id)
    );

    decode_stage u_decode (
        .clk        (clk),
        .rst        (rst),
        .if_id      (if_id),
        .wb         (wb),
        .id_ex_dst  (id_ex_dst),
        .ex_mem_dst (ex_mem_dst),
        .mem_wb_dst (mem_wb_dst),
        .pc_update  (pc_update),
        .decoded    (decoded),
        .stall      (stall)
    );

    // Bubble already muxed into decoded
    pipe_reg #(
        .payload_t (id_pkg::id_ex_t),
        .BUBBLE    (id_pkg::ID_EX_BUBBLE)
    ) id_ex_reg (
        .clk    (clk),
        .rst    (rst),
        .hold   (1'b0),
        .bubble (1'b0),
        .d      (decoded),
        .q      (id_ex)
    );

endmodule

// File: decode_checker.sv
// Decode checker modelling IF/ID, register file, PC hazard and ID/EX against the DUT each cycle
`timescale 1ns/10ps

module decode_checker (
    input  logic           clk,
    input  logic           rst,
    input  id_pkg::if_id_t fetch,
    input  id_pkg::wb_t    wb,
    input  id_pkg::dest_t  ex_mem_dst,
    input  id_pkg::dest_t  mem_wb_dst,
    input  logic           pc_update,
    input  id_pkg::id_ex_t id_ex,        // DUT output under check
    input  logic           stall,
    output int             mismatches,
    output int             data_stalls,  // Cycles held on a register conflict
    output int             call_rets     // CALL/RET accepted into the flag
);

    localparam id_pkg::ctrl_t NO_CTRL = '{alu_op: id_pkg::ALU_NONE, default: '0};

    logic [15:0]    mregs [16];    // Model register file
    id_pkg::if_id_t m_if_id;
    id_pkg::id_ex_t m_id_ex;
    logic           m_pc_haz;
    logic           in_reset = 1'b1;
    int             err_cnt = 0;
    int             dh_cnt = 0;
    int             cr_cnt = 0;

    assign mismatches  = err_cnt;
    assign data_stalls = dh_cnt;
    assign call_rets   = cr_cnt;

    // Controls straight from the opcode table
    function automatic id_pkg::ctrl_t opcode_ctrl(input logic [3:0] op);
        id_pkg::ctrl_t c;
        c = NO_CTRL;
        if (op <= 4'h6) begin  // ALU group where code follows opcode
            c.reg_write = 1'b1;
            c.alu_op    = id_pkg::alu_op_e'(op[2:0]);
            c.alu_src   = op[2];  // Shifts take imm4
        end
        case (op)
            id_pkg::LW: begin
                c.reg_write  = 1'b1;
                c.mem_read   = 1'b1;
                c.mem_to_reg = 1'b1;
                c.alu_src    = 1'b1;
                c.alu_op     = id_pkg::ALU_ADD;
            end
            id_pkg::SW: begin
                c.mem_write = 1'b1;
                c.alu_src   = 1'b1;
                c.alu_op    = id_pkg::ALU_ADD;
            end
            id_pkg::LHB, id_pkg::LLB: begin
                c.reg_write = 1'b1;
                c.load_half = 1'b1;
                c.half_spec = op[0];  // LLB is the odd one
            end
            id_pkg::BR:   c.branch = 1'b1;
            id_pkg::CALL: c.call = 1'b1;
            id_pkg::RET:  c.ret = 1'b1;
            default: ;
        endcase
        return c;
    endfunction

    // Source of IF/ID waiting on a writer ahead
    function automatic logic src_conflict();
        logic [3:0]    op;
        logic [3:0]    src_b;
        logic          reads_a;
        logic          reads_b;
        logic          hit;
        id_pkg::dest_t dst [3];
        op      = m_if_id.instr[15:12];
        reads_a = (op <= 4'h6);
        reads_b = (op <= 4'h3) || (op >= 4'h9 && op <= 4'hB);
        src_b   = (op >= 4'h9 && op <= 4'hB) ? m_if_id.instr[11:8] : m_if_id.instr[3:0];
        dst[0]  = '{wr: m_id_ex.ctrl.reg_write, rd: m_id_ex.rd};
        dst[1]  = ex_mem_dst;
        dst[2]  = mem_wb_dst;
        hit     = 1'b0;
        for (int i = 0; i < 3; i++) begin
            if (dst[i].wr && reads_a && dst[i].rd == m_if_id.instr[7:4]) hit = 1'b1;
            if (dst[i].wr && reads_b && dst[i].rd == src_b) hit = 1'b1;
        end
        return hit;
    endfunction

    function automatic logic stall_now();
        return src_conflict() || m_pc_haz;
    endfunction

    function automatic id_pkg::id_ex_t decoded_entry();
        id_pkg::id_ex_t e;
        logic [15:0]    ins;
        logic [3:0]     op;
        logic [3:0]     sel_a;
        ins   = m_if_id.instr;
        op    = ins[15:12];
        sel_a = ins[7:4];
        if (op == id_pkg::LW || op == id_pkg::SW) sel_a = id_pkg::DS_REG;
        if (op == id_pkg::CALL || op == id_pkg::RET) sel_a = id_pkg::SP_REG;
        e.ctrl        = stall_now() ? NO_CTRL : opcode_ctrl(op);
        e.read_data_1 = mregs[sel_a];
        e.read_data_2 = mregs[(op >= 4'h9 && op <= 4'hB) ? ins[11:8] : ins[3:0]];
        e.sign_ext    = (ins[15:14] == 2'b10) ? {{8{ins[7]}}, ins[7:0]}  // LW..LLB use imm8
                                              : {{12{ins[3]}}, ins[3:0]};
        e.rd          = ins[11:8];
        e.branch_cond = ins[10:8];
        e.call_target = ins[11:0];
        e.pc          = m_if_id.pc;
        return e;
    endfunction

    // Model state moves on the same edge as the DUT
    always @(posedge clk) begin
        if (rst) begin
            mregs[id_pkg::SP_REG] <= 16'hFFFF;
            m_if_id  <= '{instr: 16'h7000, pc: 16'h0000};
            m_id_ex  <= '{ctrl: NO_CTRL, default: '0};
            m_pc_haz <= 1'b0;
        end else begin
            if (wb.en) mregs[wb.rd] <= wb.data;
            m_id_ex <= decoded_entry();
            if (!stall_now()) m_if_id <= fetch;
            if (src_conflict()) dh_cnt <= dh_cnt + 1;
            if (m_pc_haz) begin
                if (pc_update) m_pc_haz <= 1'b0;
            end else if (!src_conflict() && (m_if_id.instr[15:12] == id_pkg::CALL ||
                                             m_if_id.instr[15:12] == id_pkg::RET)) begin
                m_pc_haz <= 1'b1;
                cr_cnt   <= cr_cnt + 1;
            end
        end
    end

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
            err_cnt = err_cnt + 1;
        end
    endtask

    // Mid-cycle when inputs and outputs have settled
    always @(negedge clk) begin
        if (!rst) begin
            if (in_reset) begin
                compare("id_ex.ctrl after reset", 32'(NO_CTRL), 32'(id_ex.ctrl));
                compare("stall after reset", 32'd0, 32'(stall));
            end
            compare("stall", 32'(stall_now()), 32'(stall));
            compare("id_ex.ctrl", 32'(m_id_ex.ctrl), 32'(id_ex.ctrl));
            compare("id_ex.read_data_1", 32'(m_id_ex.read_data_1), 32'(id_ex.read_data_1));
            compare("id_ex.read_data_2", 32'(m_id_ex.read_data_2), 32'(id_ex.read_data_2));
            compare("id_ex.sign_ext", 32'(m_id_ex.sign_ext), 32'(id_ex.sign_ext));
            compare("id_ex.rd", 32'(m_id_ex.rd), 32'(id_ex.rd));
            compare("id_ex.branch_cond", 32'(m_id_ex.branch_cond), 32'(id_ex.branch_cond));
            compare("id_ex.call_target", 32'(m_id_ex.call_target), 32'(id_ex.call_target));
            compare("id_ex.pc", 32'(m_id_ex.pc), 32'(id_ex.pc));
        end
        in_reset = rst;
    end

endmodule

// File: tb_top.sv
// Decode testbench top: clock, reset, seeded random stimulus, DUT and checker
`timescale 1ns/10ps

module tb_top;

    localparam int NUM_CYCLES   = 3000;
    localparam int RESET_CYCLES = 16;

    logic           clk;
    logic           rst;
    id_pkg::if_id_t fetch;
    id_pkg::wb_t    wb;
    id_pkg::dest_t  ex_mem_dst;
    id_pkg::dest_t  mem_wb_dst;
    logic           pc_update;
    id_pkg::id_ex_t id_ex;
    logic           stall;
    int             mismatches;
    int             data_stalls;
    int             call_rets;
    int             other_errors;
    integer         seed;
    logic           stalled_at_edge;  // stall as seen by the last edge

    decode_top dut (
        .clk        (clk),
        .rst        (rst),
        .fetch      (fetch),
        .wb         (wb),
        .ex_mem_dst (ex_mem_dst),
        .mem_wb_dst (mem_wb_dst),
        .pc_update  (pc_update),
        .id_ex      (id_ex),
        .stall      (stall)
    );

    decode_checker chk (
        .clk         (clk),
        .rst         (rst),
        .fetch       (fetch),
        .wb          (wb),
        .ex_mem_dst  (ex_mem_dst),
        .mem_wb_dst  (mem_wb_dst),
        .pc_update   (pc_update),
        .id_ex       (id_ex),
        .stall       (stall),
        .mismatches  (mismatches),
        .data_stalls (data_stalls),
        .call_rets   (call_rets)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 100 MHz
    end

    // Writer ahead in the pipe, active about 1 in 4
    task automatic random_dest(output id_pkg::dest_t d);
        integer r;
        r    = $random(seed);
        d.wr = (r[5:4] == 2'b00);
        d.rd = r[3:0];
    endtask

    task automatic drive_inputs(input logic take_fetch);
        integer r;
        r = $random(seed);
        if (take_fetch) begin  // Fetch frozen while stalled
            fetch.instr = r[15:0];
            fetch.pc    = fetch.pc + 16'd1;
        end
        r       = $random(seed);
        wb.en   = r[20];
        wb.rd   = r[19:16];
        wb.data = r[15:0];
        random_dest(ex_mem_dst);
        random_dest(mem_wb_dst);
        r         = $random(seed);
        pc_update = (r[9:8] == 2'b00);
    endtask

    task automatic wait_stall_low(input int limit);
        int n;
        n = 0;
        while (stall !== 1'b0 && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (stall !== 1'b0) begin
            $display("Timeout: stall still high %0d cycles after reset release", limit);
            other_errors++;
        end
    endtask

    initial begin
        seed         = 32'hd0a4;
        other_errors = 0;
        rst          = 1'b1;
        fetch        = '{instr: 16'h7000, pc: 16'h0000};
        wb           = '0;
        ex_mem_dst   = '0;
        mem_wb_dst   = '0;
        pc_update    = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        wait_stall_low(20);

        // Starts each pass mid-cycle
        for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
            stalled_at_edge = stall;
            @(posedge clk);
            #1;
            drive_inputs(!stalled_at_edge);
            @(negedge clk);
        end

        if (data_stalls == 0) begin
            $display("Stimulus never produced a data hazard stall");
            other_errors++;
        end
        if (call_rets == 0) begin
            $display("Stimulus never accepted a CALL or RET");
            other_errors++;
        end
        $display("Ran %0d cycles: %0d hazard stalls, %0d CALL/RET",
                 NUM_CYCLES, data_stalls, call_rets);
        $display("Errors: %0d mismatches, %0d other", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: all.f
id_pkg.sv
reg_file.sv
control_decoder.sv
hazard_unit.sv
pipe_reg.sv
decode_stage.sv
decode_top.sv
decode_checker.sv
tb_top.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only -Wall --timing
TOP       ?= tb_top
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -Fxq "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
